/* Bender.yml */
package:
  name: axi_iso

sources:
  - files:
      - hw/axi_iso_pkg.sv
      - hw/axi_iso_wdata_align.sv
      - hw/axi_iso_bresp_track.sv
      - hw/axi_iso_ctrl.sv
      - hw/axi_iso_regs.sv
      - hw/axi_iso_top.sv
  - target: test
    files:
      - test/axi_iso_sva.sv
      - test/axi_iso_tb.sv

/* compile.f */
hw/axi_iso_pkg.sv
hw/axi_iso_wdata_align.sv
hw/axi_iso_bresp_track.sv
hw/axi_iso_ctrl.sv
hw/axi_iso_regs.sv
hw/axi_iso_top.sv
test/axi_iso_sva.sv
test/axi_iso_tb.sv

/* hw/axi_iso_bresp_track.sv */
// outstanding write burst counter that stalls AW at the limit and flags when all B have returned
module axi_iso_bresp_track (
  input  logic                          clk,
  input  logic                          rst_n,
  // AW coming from the aligner
  input  logic                          in_awvalid,
  output logic                          in_awready,
  // AW going to the subordinate
  output logic                          dn_awvalid,
  input  logic                          dn_awready,
  // B handshake observed as it passes through the top
  input  logic                          b_valid,
  input  logic                          b_ready,
  // counter view for the controller
  output logic [axi_iso_pkg::OUT_W-1:0] outstanding,
  output logic                          drained
);

  // bursts sent downstream whose write response has not come back
  logic [axi_iso_pkg::OUT_W-1:0] count_q;
  logic full;
  logic aw_hs;
  logic b_hs;

  // at the limit no further AW may leave, the subordinate may reorder nothing we track
  assign full = count_q == axi_iso_pkg::MAX_OUTSTANDING;

  assign in_awready = dn_awready && !full;
  assign dn_awvalid = in_awvalid && !full;

  assign aw_hs = in_awvalid && in_awready;
  assign b_hs = b_valid && b_ready;

  // one burst in and one response out in the same cycle leave the count as it is
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (aw_hs && !b_hs) begin
      count_q <= count_q + 1'b1;
    end else if (b_hs && !aw_hs && !drained) begin
      // a stray response with nothing outstanding is not allowed to wrap the count
      count_q <= count_q - 1'b1;
    end
  end

  assign outstanding = count_q;
  // nothing left in flight downstream
  assign drained = count_q == '0;

endmodule

/* hw/axi_iso_ctrl.sv */
// isolation FSM that sequences alignment, response drain, isolated hold and release
module axi_iso_ctrl (
  input  logic                          clk,
  input  logic                          rst_n,
  // isolate level from the CTRL register
  input  logic                          isolate,
  // alignment handshake with the aligner
  output logic                          align_req,
  input  logic                          align_done,
  // response tracker view
  input  logic                          drained,
  input  logic [axi_iso_pkg::OUT_W-1:0] outstanding,
  // reported back to software through STATUS
  output axi_iso_pkg::iso_status_t      status
);

  axi_iso_pkg::iso_state_e state_q;
  axi_iso_pkg::iso_state_e state_d;

  // the sequence always runs through to isolated before it lets go,
  // so a request cleared midway is only acted on once the link is quiet
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      axi_iso_pkg::ST_RUN: begin
        // traffic flows freely until software asks for isolation
        if (isolate) begin
          state_d = axi_iso_pkg::ST_ALIGN;
        end
      end
      axi_iso_pkg::ST_ALIGN: begin
        // wait for AW and W to land on a common burst boundary
        if (align_done) begin
          state_d = axi_iso_pkg::ST_DRAIN;
        end
      end
      axi_iso_pkg::ST_DRAIN: begin
        // both channels are held now, wait for the last B response
        if (drained) begin
          state_d = axi_iso_pkg::ST_ISOLATED;
        end
      end
      axi_iso_pkg::ST_ISOLATED: begin
        // stay closed until software clears the isolate bit
        if (!isolate) begin
          state_d = axi_iso_pkg::ST_RUN;
        end
      end
      default: begin
        state_d = axi_iso_pkg::ST_RUN;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= axi_iso_pkg::ST_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // the aligner keeps holding through drain and isolated, and only ST_RUN releases it,
  // which is reached from ST_ISOLATED where align_done is already high
  assign align_req = state_q != axi_iso_pkg::ST_RUN;

  // software sees the state together with the live outstanding count
  assign status = '{state: state_q, outstanding: outstanding};

endmodule

/* hw/axi_iso_pkg.sv */
// shared sizes, channel and register structs and controller state for the write-path isolator
package axi_iso_pkg;

  // awlen is zero based, so the longest burst is sixteen beats
  localparam int MAX_BURST_LEN = 16;
  localparam int LEN_W = 4;

  // skew budget between AW and W, counted in maximum-length bursts
  localparam int MAX_TXN_SKEW = 2;
  localparam int EXCESS_MAX = MAX_TXN_SKEW * MAX_BURST_LEN;
  // one bit more than strictly needed so the counters never wrap near the limit
  localparam int EXCESS_W = 6;

  // write bursts that may be awaiting a B response downstream
  localparam int MAX_OUTSTANDING = 8;
  localparam int OUT_W = 4;

  // register map, word addressed
  localparam int REG_ADDR_W = 2;
  localparam logic [REG_ADDR_W-1:0] REG_CTRL = 2'd0;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS = 2'd1;

  // AW channel, only the fields the aligner looks at
  typedef struct packed {
    logic             valid;
    logic [LEN_W-1:0] len;
  } aw_req_t;

  // W channel, last is carried only to be forwarded
  typedef struct packed {
    logic valid;
    logic last;
  } w_req_t;

  // strobe based register request, no back-pressure
  typedef struct packed {
    logic                  wr;
    logic                  rd;
    logic [REG_ADDR_W-1:0] addr;
    logic [31:0]           wdata;
  } reg_req_t;

  // read data comes back one cycle after the read strobe
  typedef struct packed {
    logic        rd_valid;
    logic [31:0] rdata;
  } reg_rsp_t;

  // isolation sequence, encoded as it appears in STATUS bits 1:0
  typedef enum logic [1:0] {
    ST_RUN      = 2'd0,
    ST_ALIGN    = 2'd1,
    ST_DRAIN    = 2'd2,
    ST_ISOLATED = 2'd3
  } iso_state_e;

  // what the controller reports back to software
  typedef struct packed {
    iso_state_e       state;
    logic [OUT_W-1:0] outstanding;
  } iso_status_t;

endpackage

/* hw/axi_iso_regs.sv */
// control and status register block with a strobe based read and write port
module axi_iso_regs (
  input  logic                     clk,
  input  logic                     rst_n,
  // register port from software
  input  axi_iso_pkg::reg_req_t    reg_req,
  output axi_iso_pkg::reg_rsp_t    reg_rsp,
  // isolate level towards the controller
  output logic                     isolate,
  // controller state for the STATUS register
  input  axi_iso_pkg::iso_status_t status
);

  // CTRL bit 0
  logic isolate_q;
  // read response registers
  logic rd_valid_q;
  logic [31:0] rdata_q;
  // read value selected by the current address
  logic [31:0] rdata_d;

  // only CTRL is writable, and writes to STATUS or unused addresses are dropped
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      isolate_q <= 1'b0;
    end else if (reg_req.wr && (reg_req.addr == axi_iso_pkg::REG_CTRL)) begin
      isolate_q <= reg_req.wdata[0];
    end
  end

  // STATUS packs the state into bits 1:0 and the outstanding count into bits 7:4
  always_comb begin
    unique case (reg_req.addr)
      axi_iso_pkg::REG_CTRL: begin
        rdata_d = {31'b0, isolate_q};
      end
      axi_iso_pkg::REG_STATUS: begin
        rdata_d = {24'b0, status.outstanding, 2'b0, status.state};
      end
      default: begin
        // unmapped addresses read back as zero
        rdata_d = '0;
      end
    endcase
  end

  // the valid strobe follows every read strobe by exactly one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= reg_req.rd;
    end
  end

  // read data is captured on each read strobe and held until the next one
  always_ff @(posedge clk) begin
    if (reg_req.rd) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rsp = '{rd_valid: rd_valid_q, rdata: rdata_q};
  assign isolate = isolate_q;

endmodule

/* hw/axi_iso_top.sv */
// write-path isolator top that wires the register block, controller, aligner and response tracker
module axi_iso_top (
  input  logic                            clk,
  input  logic                            rst_n,
  // upstream AW and W from the manager
  input  axi_iso_pkg::aw_req_t            up_aw,
  output logic                            up_awready,
  input  axi_iso_pkg::w_req_t             up_w,
  output logic                            up_wready,
  // downstream AW and W to the subordinate
  output logic                            dn_awvalid,
  output logic [axi_iso_pkg::LEN_W-1:0]   dn_awlen,
  input  logic                            dn_awready,
  output logic                            dn_wvalid,
  output logic                            dn_wlast,
  input  logic                            dn_wready,
  // write response, passed through untouched
  input  logic                            dn_bvalid,
  input  logic                            up_bready,
  output logic                            up_bvalid,
  output logic                            dn_bready,
  // register port
  input  axi_iso_pkg::reg_req_t           reg_req,
  output axi_iso_pkg::reg_rsp_t           reg_rsp
);

  // control path
  logic isolate;
  logic align_req;
  logic align_done;
  logic drained;
  logic [axi_iso_pkg::OUT_W-1:0] outstanding;
  axi_iso_pkg::iso_status_t status;

  // AW handshake between the aligner and the response tracker
  logic al_awvalid;
  logic al_awready;

  // the length and last fields ride along with their valid, the hold is in the handshake
  assign dn_awlen = up_aw.len;
  assign dn_wlast = up_w.last;

  // B is never held, the tracker only watches it
  assign up_bvalid = dn_bvalid;
  assign dn_bready = up_bready;

  axi_iso_regs i_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .reg_req (reg_req),
    .reg_rsp (reg_rsp),
    .isolate (isolate),
    .status  (status)
  );

  axi_iso_ctrl i_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .isolate     (isolate),
    .align_req   (align_req),
    .align_done  (align_done),
    .drained     (drained),
    .outstanding (outstanding),
    .status      (status)
  );

  // the aligner sees the tracker as its downstream AW port
  axi_iso_wdata_align i_align (
    .clk        (clk),
    .rst_n      (rst_n),
    .up_aw      (up_aw),
    .up_awready (up_awready),
    .up_w       (up_w),
    .up_wready  (up_wready),
    .dn_awvalid (al_awvalid),
    .dn_awready (al_awready),
    .dn_wvalid  (dn_wvalid),
    .dn_wready  (dn_wready),
    .align_req  (align_req),
    .align_done (align_done)
  );

  axi_iso_bresp_track i_track (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_awvalid  (al_awvalid),
    .in_awready  (al_awready),
    .dn_awvalid  (dn_awvalid),
    .dn_awready  (dn_awready),
    .b_valid     (dn_bvalid),
    .b_ready     (up_bready),
    .outstanding (outstanding),
    .drained     (drained)
  );

endmodule

/* hw/axi_iso_wdata_align.sv */
// AW/W beat aligner that bounds channel skew, forces both channels into step and holds upstream
module axi_iso_wdata_align (
  input  logic                 clk,
  input  logic                 rst_n,
  // upstream manager side
  input  axi_iso_pkg::aw_req_t up_aw,
  output logic                 up_awready,
  input  axi_iso_pkg::w_req_t  up_w,
  output logic                 up_wready,
  // downstream side, towards the response tracker and subordinate
  output logic                 dn_awvalid,
  input  logic                 dn_awready,
  output logic                 dn_wvalid,
  input  logic                 dn_wready,
  // alignment handshake with the isolation controller
  input  logic                 align_req,
  output logic                 align_done
);

  // beats promised by accepted AW requests that W has not delivered yet
  logic [axi_iso_pkg::EXCESS_W-1:0] excess_aw_q;
  // W beats that arrived before the AW request that will claim them
  logic [axi_iso_pkg::EXCESS_W-1:0] excess_w_q;

  // upstream handshakes, counted whatever happens further down
  logic aw_hs;
  logic w_hs;

  // working values carry one extra bit so the sign of the skew is visible
  logic [axi_iso_pkg::EXCESS_W:0] aw_beats;
  logic [axi_iso_pkg::EXCESS_W:0] balance;
  logic [axi_iso_pkg::EXCESS_W:0] balance_next;
  logic [axi_iso_pkg::EXCESS_W:0] deficit_next;

  // decision terms
  logic aw_full;
  logic w_full;
  logic aw_ahead;
  logic w_ahead;
  logic aligned;
  logic hold_aw;
  logic hold_w;

  assign aw_hs = up_aw.valid && up_awready;
  assign w_hs = up_w.valid && up_wready;

  // awlen counts from zero, so a burst brings len plus one beats
  assign aw_beats = {{(axi_iso_pkg::EXCESS_W + 1 - axi_iso_pkg::LEN_W){1'b0}}, up_aw.len} + 1'b1;

  // net skew in two's complement, positive while AW leads and negative while W leads
  assign balance = {1'b0, excess_aw_q} - {1'b0, excess_w_q};

  // an AW first eats any early W beats and a W beat first eats any promised AW beats,
  // which falls out of adding both into one signed balance
  always_comb begin
    balance_next = balance;
    if (aw_hs) begin
      balance_next = balance_next + aw_beats;
    end
    if (w_hs) begin
      balance_next = balance_next - 1'b1;
    end
  end

  // magnitude of the skew when W ends up ahead
  assign deficit_next = '0 - balance_next;

  // split the balance back into the two counters, so at most one is ever nonzero
  // even when AW and W are accepted in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      excess_aw_q <= '0;
      excess_w_q <= '0;
    end else if (balance_next[axi_iso_pkg::EXCESS_W]) begin
      excess_aw_q <= '0;
      excess_w_q <= deficit_next[axi_iso_pkg::EXCESS_W-1:0];
    end else begin
      excess_aw_q <= balance_next[axi_iso_pkg::EXCESS_W-1:0];
      excess_w_q <= '0;
    end
  end

  // AW stops when one more maximum-length burst would overrun the skew budget
  assign aw_full = excess_aw_q >= (axi_iso_pkg::EXCESS_MAX - axi_iso_pkg::MAX_BURST_LEN);
  // W stops one beat short of the budget, so 31 early beats are the most we take
  assign w_full = excess_w_q >= (axi_iso_pkg::EXCESS_MAX - 1);

  // only one counter can be nonzero, so a nonzero count means that side leads
  assign aw_ahead = excess_aw_q != '0;
  assign w_ahead = excess_w_q != '0;
  assign aligned = !aw_ahead && !w_ahead;

  // done means both channels sit on a burst boundary while alignment is requested
  assign align_done = align_req && aligned;

  // during alignment the leading side waits for the other to catch up,
  // and once aligned both sides stay closed until the request drops
  assign hold_aw = aw_full || (align_req && aw_ahead) || align_done;
  assign hold_w = w_full || (align_req && w_ahead) || align_done;

  // a held channel shows ready low upstream and valid low downstream
  assign up_awready = dn_awready && !hold_aw;
  assign dn_awvalid = up_aw.valid && !hold_aw;
  assign up_wready = dn_wready && !hold_w;
  assign dn_wvalid = up_w.valid && !hold_w;

endmodule

/* test/axi_iso_sva.sv */
// concurrent checks on the AW/W aligner skew counters, channel holds and the align handshake
module axi_iso_sva (
  input logic                             clk,
  input logic                             rst_n,
  input logic                             align_req,
  input logic                             align_done,
  input logic [axi_iso_pkg::EXCESS_W-1:0] excess_aw,
  input logic [axi_iso_pkg::EXCESS_W-1:0] excess_w,
  input logic                             dn_awvalid,
  input logic                             dn_wvalid
);

  // number of assertion failures seen so far
  int fail_count = 0;

  // only one side of the link may lead at any time, and never by the whole skew budget
  a_one_side_ahead: assert property (@(posedge clk) disable iff (!rst_n)
    !((excess_aw != '0) && (excess_w != '0)) &&
    (excess_aw < axi_iso_pkg::EXCESS_MAX) && (excess_w < axi_iso_pkg::EXCESS_MAX))
    else begin
      fail_count++;
      $error("AW and W skew counters are both nonzero or over the skew budget");
    end

  // the link is only released from an aligned state
  a_req_falls_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(align_req) |-> $past(align_done))
    else begin
      fail_count++;
      $error("align_req fell without align_done");
    end

  // once aligned under a request nothing may leave towards the subordinate
  a_aligned_held: assert property (@(posedge clk) disable iff (!rst_n)
    align_done |-> (!dn_awvalid && !dn_wvalid))
    else begin
      fail_count++;
      $error("valid seen downstream while aligned and held");
    end

  // the leading channel waits for the other while alignment is requested
  a_aw_lead_held: assert property (@(posedge clk) disable iff (!rst_n)
    (align_req && (excess_aw != '0)) |-> !dn_awvalid)
    else begin
      fail_count++;
      $error("AW valid seen downstream while AW leads during alignment");
    end

  a_w_lead_held: assert property (@(posedge clk) disable iff (!rst_n)
    (align_req && (excess_w != '0)) |-> !dn_wvalid)
    else begin
      fail_count++;
      $error("W valid seen downstream while W leads during alignment");
    end

endmodule

bind axi_iso_wdata_align axi_iso_sva i_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .align_req  (align_req),
  .align_done (align_done),
  .excess_aw  (excess_aw_q),
  .excess_w   (excess_w_q),
  .dn_awvalid (dn_awvalid),
  .dn_wvalid  (dn_wvalid)
);

/* test/axi_iso_tb.sv */
// testbench for the AXI write-path isolator, directed tests over AW, W, B and the register port
module axi_iso_tb;

  // cycles any single wait may take before it gives up
  localparam int TIMEOUT = 200;

  logic clk;
  logic rst_n;
  axi_iso_pkg::aw_req_t up_aw;
  logic up_awready;
  axi_iso_pkg::w_req_t up_w;
  logic up_wready;
  logic dn_awvalid;
  logic [axi_iso_pkg::LEN_W-1:0] dn_awlen;
  logic dn_awready;
  logic dn_wvalid;
  logic dn_wlast;
  logic dn_wready;
  logic dn_bvalid = 1'b0;
  logic up_bready;
  logic up_bvalid;
  logic dn_bready;
  axi_iso_pkg::reg_req_t reg_req;
  axi_iso_pkg::reg_rsp_t reg_rsp;

  // the subordinate model only returns B responses while this is high
  logic b_enable;

  // what the subordinate has seen, counted from downstream handshakes
  int aw_bursts = 0;
  int aw_beats = 0;
  int w_beats = 0;
  int w_lasts = 0;
  int b_count = 0;

  int checks = 0;
  int errors = 0;
  int timeouts = 0;
  int seed = 32'h6587;

  // every port name matches a testbench signal
  axi_iso_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // handshakes are decided by values that hold from the falling edge up to the next rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (dn_awvalid && dn_awready) begin
        aw_bursts = aw_bursts + 1;
        aw_beats = aw_beats + dn_awlen + 1;
      end
      if (dn_wvalid && dn_wready) begin
        w_beats = w_beats + 1;
        if (dn_wlast) begin
          w_lasts = w_lasts + 1;
        end
      end
      // B is not touched by the isolator, so each direction follows its source
      expect_equal(up_bvalid, dn_bvalid, "B valid passed through to the manager");
      expect_equal(dn_bready, up_bready, "B ready passed through to the subordinate");
    end
  end

  // a burst is owed a response once both its AW and its last W beat have arrived
  always @(posedge clk) begin : b_responder
    int owed;
    if (!rst_n) begin
      dn_bvalid <= 1'b0;
    end else begin
      if (dn_bvalid && dn_bready) begin
        b_count = b_count + 1;
      end
      owed = ((aw_bursts < w_lasts) ? aw_bursts : w_lasts) - b_count;
      dn_bvalid <= b_enable && (owed > 0);
    end
  end

  task automatic expect_equal(input int got, input int exp, input string what);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("timed out at %0t while waiting for %s", $time, what);
  endtask

  // STATUS layout, state in bits 1:0 and outstanding bursts in bits 7:4
  function automatic int status_word(input axi_iso_pkg::iso_state_e st, input int outstanding);
    return (outstanding << 4) | int'(st);
  endfunction

  task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
    @(posedge clk);
    reg_req <= '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
    @(posedge clk);
    reg_req <= '0;
  endtask

  // read data comes back exactly one cycle after the strobe
  task automatic read_reg(input logic [1:0] addr, output logic [31:0] data);
    @(posedge clk);
    reg_req <= '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: 32'h0};
    @(posedge clk);
    reg_req <= '0;
    @(negedge clk);
    expect_equal(reg_rsp.rd_valid, 1, "read response valid one cycle after the strobe");
    data = reg_rsp.rdata;
  endtask

  task automatic wait_for_state(input axi_iso_pkg::iso_state_e st);
    logic [31:0] d;
    int t;
    t = 0;
    read_reg(axi_iso_pkg::REG_STATUS, d);
    while ((d[1:0] != st) && (t < TIMEOUT)) begin
      read_reg(axi_iso_pkg::REG_STATUS, d);
      t++;
    end
    if (d[1:0] != st) begin
      note_timeout($sformatf("STATUS state %0d", st));
    end
  endtask

  task automatic send_aw(input logic [3:0] len);
    int t;
    t = 0;
    @(posedge clk);
    up_aw <= '{valid: 1'b1, len: len};
    @(negedge clk);
    while (!up_awready && (t < TIMEOUT)) begin
      @(negedge clk);
      t++;
    end
    if (!up_awready) begin
      note_timeout("AW ready");
    end
    @(posedge clk);
    up_aw <= '0;
  endtask

  // a burst of len plus one beats, last marked on the final beat
  task automatic send_w_burst(input logic [3:0] len);
    int t;
    for (int i = 0; i <= len; i++) begin
      t = 0;
      @(posedge clk);
      up_w <= '{valid: 1'b1, last: (i == len)};
      @(negedge clk);
      while (!up_wready && (t < TIMEOUT)) begin
        @(negedge clk);
        t++;
      end
      if (!up_wready) begin
        note_timeout("W ready");
        break;
      end
    end
    @(posedge clk);
    up_w <= '0;
  endtask

  task automatic wait_b_drained();
    int t;
    t = 0;
    @(negedge clk);
    while ((b_count != aw_bursts) && (t < TIMEOUT)) begin
      @(negedge clk);
      t++;
    end
    if (b_count != aw_bursts) begin
      note_timeout("all write responses");
    end
  endtask

  // random-length bursts with matching W must come out downstream unchanged in number
  task automatic run_traffic(input int bursts);
    int aw0;
    int ab0;
    int w0;
    int l0;
    int beats;
    logic [31:0] rnd;
    logic [31:0] d;
    logic [3:0] len;
    aw0 = aw_bursts;
    ab0 = aw_beats;
    w0 = w_beats;
    l0 = w_lasts;
    beats = 0;
    for (int k = 0; k < bursts; k++) begin
      rnd = $random(seed);
      len = rnd[3:0];
      beats += len + 1;
      fork
        send_aw(len);
        send_w_burst(len);
      join
    end
    expect_equal(aw_bursts - aw0, bursts, "downstream AW bursts");
    expect_equal(aw_beats - ab0, beats, "downstream AW beats");
    expect_equal(w_beats - w0, beats, "downstream W beats");
    expect_equal(w_lasts - l0, bursts, "downstream W last beats");
    wait_b_drained();
    read_reg(axi_iso_pkg::REG_STATUS, d);
    expect_equal(d, status_word(axi_iso_pkg::ST_RUN, 0), "STATUS after traffic");
  endtask

  task automatic test_reset_and_traffic();
    logic [31:0] d;
    read_reg(axi_iso_pkg::REG_CTRL, d);
    expect_equal(d, 0, "CTRL after reset");
    read_reg(axi_iso_pkg::REG_STATUS, d);
    expect_equal(d, 0, "STATUS after reset");
    run_traffic(8);
  endtask

  // 31 early W beats fit the skew budget, then W is held until AW catches up
  task automatic test_skew_limit();
    int w0;
    int t;
    w0 = w_beats;
    send_w_burst(4'd15);
    send_w_burst(4'd14);
    expect_equal(w_beats - w0, axi_iso_pkg::EXCESS_MAX - 1, "W beats accepted without AW");
    repeat (8) begin
      @(negedge clk);
      expect_equal(up_wready, 0, "W ready held at the skew limit");
    end
    send_aw(4'd15);
    send_aw(4'd14);
    t = 0;
    @(negedge clk);
    while (!up_wready && (t < TIMEOUT)) begin
      @(negedge clk);
      t++;
    end
    expect_equal(up_wready, 1, "W ready released once AW balanced the beats");
    wait_b_drained();
  endtask

  task automatic test_isolate_w_ahead();
    logic [31:0] d;
    send_w_burst(4'd3);
    write_reg(axi_iso_pkg::REG_CTRL, 32'h1);
    wait_for_state(axi_iso_pkg::ST_ALIGN);
    @(negedge clk);
    expect_equal(up_wready, 0, "W held while it leads during alignment");
    expect_equal(up_awready, 1, "AW open while it trails during alignment");
    send_aw(4'd3);
    wait_for_state(axi_iso_pkg::ST_ISOLATED);
    expect_equal(aw_beats, w_beats, "downstream beats balanced at isolation");
    repeat (10) begin
      @(negedge clk);
      expect_equal(up_awready, 0, "AW ready low while isolated");
      expect_equal(up_wready, 0, "W ready low while isolated");
    end
    read_reg(axi_iso_pkg::REG_CTRL, d);
    expect_equal(d, 1, "CTRL isolate readback");
  endtask

  task automatic test_release();
    write_reg(axi_iso_pkg::REG_CTRL, 32'h0);
    wait_for_state(axi_iso_pkg::ST_RUN);
    run_traffic(4);
  endtask

  // withheld responses stop isolation in drain until they come back
  task automatic test_drain();
    logic [31:0] d;
    @(posedge clk);
    b_enable <= 1'b0;
    fork
      send_aw(4'd2);
      send_w_burst(4'd2);
    join
    fork
      send_aw(4'd5);
      send_w_burst(4'd5);
    join
    write_reg(axi_iso_pkg::REG_CTRL, 32'h1);
    wait_for_state(axi_iso_pkg::ST_DRAIN);
    repeat (10) @(posedge clk);
    read_reg(axi_iso_pkg::REG_STATUS, d);
    expect_equal(d, status_word(axi_iso_pkg::ST_DRAIN, 2), "STATUS while draining");
    @(posedge clk);
    b_enable <= 1'b1;
    wait_for_state(axi_iso_pkg::ST_ISOLATED);
    read_reg(axi_iso_pkg::REG_STATUS, d);
    expect_equal(d, status_word(axi_iso_pkg::ST_ISOLATED, 0), "STATUS after drain");
  endtask

  task automatic test_outstanding_limit();
    logic [31:0] d;
    int aw0;
    int b0;
    int t;
    aw0 = aw_bursts;
    @(posedge clk);
    b_enable <= 1'b0;
    for (int k = 0; k < axi_iso_pkg::MAX_OUTSTANDING; k++) begin
      fork
        send_aw(4'd0);
        send_w_burst(4'd0);
      join
    end
    read_reg(axi_iso_pkg::REG_STATUS, d);
    expect_equal(d, status_word(axi_iso_pkg::ST_RUN, 8), "STATUS at the outstanding limit");
    // one more AW stays pending while no response comes back
    @(posedge clk);
    up_aw <= '{valid: 1'b1, len: 4'd0};
    repeat (10) begin
      @(negedge clk);
      expect_equal(up_awready, 0, "AW held at the outstanding limit");
    end
    expect_equal(aw_bursts - aw0, axi_iso_pkg::MAX_OUTSTANDING, "AW bursts sent downstream");
    b0 = b_count;
    // a response offered while the manager stalls B does not count as returned
    @(posedge clk);
    up_bready <= 1'b0;
    b_enable <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      expect_equal(up_awready, 0, "AW held while the manager stalls B");
    end
    expect_equal(b_count, b0, "no response accepted while B ready is low");
    @(posedge clk);
    up_bready <= 1'b1;
    t = 0;
    @(negedge clk);
    while (!up_awready && (t < TIMEOUT)) begin
      @(negedge clk);
      t++;
    end
    if (!up_awready) begin
      note_timeout("AW ready after a write response");
    end
    expect_equal(b_count > b0, 1, "AW released only after a response returned");
    @(posedge clk);
    up_aw <= '0;
    send_w_burst(4'd0);
    wait_b_drained();
  endtask

  initial begin
    rst_n = 1'b0;
    up_aw = '0;
    up_w = '0;
    dn_awready = 1'b1;
    dn_wready = 1'b1;
    up_bready = 1'b1;
    reg_req = '0;
    b_enable = 1'b1;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_and_traffic();
    test_skew_limit();
    test_isolate_w_ahead();
    test_release();
    test_drain();
    test_release();
    test_outstanding_limit();
    repeat (4) @(posedge clk);
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, i_dut.i_align.i_sva.fail_count);
    if ((errors == 0) && (timeouts == 0) && (i_dut.i_align.i_sva.fail_count == 0)) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
